//--- hdl/fb_pkg.sv
package fb_pkg;

    // pixel and address widths
    typedef logic [3:0] pixel_t;
    typedef logic [9:0] fb_addr_t;
    typedef logic [7:0] fb_count_t;

    // screen geometry, visible area first
    localparam int H_ACTIVE = 32;
    localparam int V_ACTIVE = 24;
    localparam int H_TOTAL = 40;
    localparam int V_TOTAL = 28;
    localparam int H_SYNC_FIRST = 34;
    localparam int H_SYNC_LAST = 35;
    localparam int V_SYNC_FIRST = 25;
    localparam int V_SYNC_LAST = 26;
    localparam int FB_PIXELS = H_ACTIVE * V_ACTIVE;

    // register map, byte addresses
    localparam logic [15:0] PIX_BASE = 16'h0000;
    localparam logic [15:0] CTRL_ADDR = 16'h1000;
    localparam logic [15:0] STATUS_ADDR = 16'h1004;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // manager side of the AXI4-Lite bus
    typedef struct packed {
        logic        awvalid;
        logic [15:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [15:0] araddr;
        logic        rready;
    } axil_req_t;

    // subordinate side
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        fill_idle,
        fill_armed,
        fill_busy
    } fill_state_t;

endpackage

//--- hdl/fb_bank.sv
`timescale 1ns/10ps

module fb_bank
    import fb_pkg::*;
(
    input  logic     clock,
    // port a
    input  logic     we_a,
    input  fb_addr_t addr_a,
    input  pixel_t   wdata_a,
    output pixel_t   rdata_a,
    // port b
    input  logic     we_b,
    input  fb_addr_t addr_b,
    input  pixel_t   wdata_b,
    output pixel_t   rdata_b
);

    pixel_t mem [FB_PIXELS];

    // both ports read the old contents on a collision
    always_ff @(posedge clock) begin
        if (we_a) begin
            mem[addr_a] <= wdata_a;
        end
        if (we_b) begin
            mem[addr_b] <= wdata_b;
        end
        rdata_a <= mem[addr_a];
        rdata_b <= mem[addr_b];
    end

endmodule

//--- hdl/fb_double_buffer.sv
`timescale 1ns/10ps

module fb_double_buffer
    import fb_pkg::*;
(
    input  logic     clock,
    input  logic     rst,
    input  logic     vsync,
    // read ports, always the front bank
    input  fb_addr_t rd1_addr,
    output pixel_t   rd1_data,
    input  fb_addr_t rd2_addr,
    output pixel_t   rd2_data,
    // write ports, always the back bank
    input  logic     wr1_en,
    input  fb_addr_t wr1_addr,
    input  pixel_t   wr1_data,
    input  logic     wr2_en,
    input  fb_addr_t wr2_addr,
    input  pixel_t   wr2_data,
    output logic     front_sel,
    output logic     swap_pulse
);

    logic   vsync_q;
    logic   front_q;
    pixel_t bank_rd_a [2];
    pixel_t bank_rd_b [2];

    always_ff @(posedge clock) begin
        if (rst) begin
            vsync_q <= 1'b0;
            front_sel <= 1'b0;
            front_q <= 1'b0;
            swap_pulse <= 1'b0;
        end else begin
            vsync_q <= vsync;
            // swap on the falling edge of vsync
            swap_pulse <= vsync_q && !vsync;
            if (vsync_q && !vsync) begin
                front_sel <= !front_sel;
            end
            // matches the registered bank read
            front_q <= front_sel;
        end
    end

    for (genvar gi = 0; gi < 2; gi++) begin : g_bank
        logic is_front;

        assign is_front = (front_sel == 1'(gi));

        // port a is display read or host write, port b is host read or fill
        fb_bank i_bank (
            .clock   (clock),
            .we_a    (wr1_en && !is_front),
            .addr_a  (is_front ? rd1_addr : wr1_addr),
            .wdata_a (wr1_data),
            .rdata_a (bank_rd_a[gi]),
            .we_b    (wr2_en && !is_front),
            .addr_b  (is_front ? rd2_addr : wr2_addr),
            .wdata_b (wr2_data),
            .rdata_b (bank_rd_b[gi])
        );
    end

    assign rd1_data = bank_rd_a[front_q];
    assign rd2_data = bank_rd_b[front_q];

endmodule

//--- hdl/scan_timing.sv
`timescale 1ns/10ps

module scan_timing
    import fb_pkg::*;
(
    input  logic     clock,
    input  logic     rst,
    output fb_addr_t scan_addr,
    input  pixel_t   scan_pixel,
    output pixel_t   pixel_out,
    output logic     pixel_valid,
    output logic     hsync,
    output logic     vsync
);

    logic [5:0] h_cnt;
    logic [4:0] v_cnt;
    logic       active;

    always_ff @(posedge clock) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == 6'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == 5'(V_TOTAL - 1)) ? '0 : v_cnt + 5'd1;
        end else begin
            h_cnt <= h_cnt + 6'd1;
        end
    end

    assign active = (h_cnt < 6'(H_ACTIVE)) && (v_cnt < 5'(V_ACTIVE));

    // linear index, parked at zero during blanking
    assign scan_addr = active ? fb_addr_t'(int'(v_cnt) * H_ACTIVE + int'(h_cnt)) : '0;

    // one cycle late so the bank read lines up
    always_ff @(posedge clock) begin
        if (rst) begin
            pixel_valid <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end else begin
            pixel_valid <= active;
            hsync <= (h_cnt >= 6'(H_SYNC_FIRST)) && (h_cnt <= 6'(H_SYNC_LAST));
            vsync <= (v_cnt >= 5'(V_SYNC_FIRST)) && (v_cnt <= 5'(V_SYNC_LAST));
        end
    end

    // blank outside the visible area
    assign pixel_out = pixel_valid ? scan_pixel : '0;

endmodule

//--- hdl/fill_engine.sv
`timescale 1ns/10ps

module fill_engine
    import fb_pkg::*;
(
    input  logic     clock,
    input  logic     rst,
    input  logic     fill_start,
    input  pixel_t   fill_color,
    input  logic     swap_pulse,
    output logic     fill_we,
    output fb_addr_t fill_addr,
    output pixel_t   fill_data,
    output logic     fill_active
);

    fill_state_t state;
    fb_addr_t    addr_cnt;
    pixel_t      color_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= fill_idle;
            addr_cnt <= '0;
        end else begin
            case (state)
                fill_idle: begin
                    if (fill_start) begin
                        state <= fill_armed;
                    end
                end
                // wait for the new back buffer
                fill_armed: begin
                    addr_cnt <= '0;
                    if (swap_pulse) begin
                        state <= fill_busy;
                    end
                end
                fill_busy: begin
                    addr_cnt <= addr_cnt + fb_addr_t'(1);
                    if (addr_cnt == fb_addr_t'(FB_PIXELS - 1)) begin
                        state <= fill_idle;
                    end
                end
                default: state <= fill_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == fill_idle && fill_start) begin
            color_q <= fill_color;
        end
    end

    // one pixel per cycle while busy
    assign fill_we = (state == fill_busy);
    assign fill_addr = addr_cnt;
    assign fill_data = color_q;
    assign fill_active = (state != fill_idle);

endmodule

//--- hdl/axil_fb_slave.sv
`timescale 1ns/10ps

module axil_fb_slave
    import fb_pkg::*;
(
    input  logic      clock,
    input  logic      rst,
    input  axil_req_t req,
    output axil_rsp_t rsp,
    // host side of the frame buffer
    output logic      pix_we,
    output fb_addr_t  pix_waddr,
    output pixel_t    pix_wdata,
    output fb_addr_t  pix_raddr,
    input  pixel_t    pix_rdata,
    // status inputs
    input  logic      front_sel,
    input  logic      fill_active,
    input  logic      vsync,
    // fill command
    output logic      fill_start,
    output pixel_t    fill_color
);

    logic        wr_accept;
    logic        bvalid_q;
    logic        ar_accept;
    logic        rd_pending;
    logic        addr_phase;
    logic        rvalid_q;
    logic        first_beat;
    logic [15:0] rd_addr_q;
    logic [31:0] live_rdata;
    logic [31:0] rdata_hold;
    logic        vsync_q;
    fb_count_t   frame_cnt;

    // word aligned and inside the pixel window
    function automatic logic pix_hit(input logic [15:0] addr);
        logic [15:0] offs;
        offs = addr - PIX_BASE;
        return (offs[1:0] == 2'b00) && (offs[15:2] < 14'(FB_PIXELS));
    endfunction

    function automatic fb_addr_t pix_index(input logic [15:0] addr);
        logic [15:0] offs;
        offs = addr - PIX_BASE;
        return offs[11:2];
    endfunction

    // address and data must arrive together, no back-to-back while a
    // response or a fill is outstanding
    assign wr_accept = req.awvalid && req.wvalid && !bvalid_q && !fill_active;

    assign pix_we = wr_accept && req.wstrb[0] && pix_hit(req.awaddr);
    assign pix_waddr = pix_index(req.awaddr);
    assign pix_wdata = req.wdata[3:0];
    assign fill_start = wr_accept && req.wstrb[0] && (req.awaddr == CTRL_ADDR);
    assign fill_color = req.wdata[3:0];

    always_ff @(posedge clock) begin
        if (rst) begin
            bvalid_q <= 1'b0;
        end else if (wr_accept) begin
            bvalid_q <= 1'b1;
        end else if (req.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    // read path: accept, address to the bank, then data
    assign ar_accept = req.arvalid && !rd_pending;

    always_ff @(posedge clock) begin
        if (rst) begin
            rd_pending <= 1'b0;
            addr_phase <= 1'b0;
            rvalid_q <= 1'b0;
            first_beat <= 1'b0;
        end else begin
            addr_phase <= ar_accept;
            first_beat <= addr_phase;
            if (ar_accept) begin
                rd_pending <= 1'b1;
            end else if (rvalid_q && req.rready) begin
                rd_pending <= 1'b0;
            end
            if (addr_phase) begin
                rvalid_q <= 1'b1;
            end else if (req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ar_accept) begin
            rd_addr_q <= req.araddr;
        end
        // keeps rdata stable while the manager stalls
        if (first_beat) begin
            rdata_hold <= live_rdata;
        end
    end

    assign pix_raddr = pix_index(rd_addr_q);

    always_comb begin
        live_rdata = '0;
        if (pix_hit(rd_addr_q)) begin
            live_rdata[3:0] = pix_rdata;
        end else if (rd_addr_q == STATUS_ADDR) begin
            live_rdata[0] = front_sel;
            live_rdata[1] = fill_active;
            live_rdata[15:8] = frame_cnt;
        end
    end

    // frames counted on vsync fall
    always_ff @(posedge clock) begin
        if (rst) begin
            vsync_q <= 1'b0;
            frame_cnt <= '0;
        end else begin
            vsync_q <= vsync;
            if (vsync_q && !vsync) begin
                frame_cnt <= frame_cnt + fb_count_t'(1);
            end
        end
    end

    always_comb begin
        rsp = '0;
        rsp.awready = wr_accept;
        rsp.wready = wr_accept;
        rsp.bvalid = bvalid_q;
        rsp.bresp = RESP_OKAY;
        rsp.arready = !rd_pending;
        rsp.rvalid = rvalid_q;
        rsp.rdata = first_beat ? live_rdata : rdata_hold;
        rsp.rresp = RESP_OKAY;
    end

endmodule

//--- hdl/fb_top.sv
`timescale 1ns/10ps

module fb_top
    import fb_pkg::*;
(
    input  logic      clock,
    input  logic      rst,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output pixel_t    pixel_out,
    output logic      pixel_valid,
    output logic      hsync,
    output logic      vsync
);

    // host port
    logic     pix_we;
    fb_addr_t pix_waddr;
    pixel_t   pix_wdata;
    fb_addr_t pix_raddr;
    pixel_t   pix_rdata;
    // fill port
    logic     fill_start;
    pixel_t   fill_color;
    logic     fill_we;
    fb_addr_t fill_addr;
    pixel_t   fill_data;
    logic     fill_active;
    // display port
    fb_addr_t scan_addr;
    pixel_t   scan_pixel;
    logic     front_sel;
    logic     swap_pulse;

    axil_fb_slave i_axil_fb_slave (
        .clock       (clock),
        .rst         (rst),
        .req         (axil_req),
        .rsp         (axil_rsp),
        .pix_we      (pix_we),
        .pix_waddr   (pix_waddr),
        .pix_wdata   (pix_wdata),
        .pix_raddr   (pix_raddr),
        .pix_rdata   (pix_rdata),
        .front_sel   (front_sel),
        .fill_active (fill_active),
        .vsync       (vsync),
        .fill_start  (fill_start),
        .fill_color  (fill_color)
    );

    fill_engine i_fill_engine (
        .clock       (clock),
        .rst         (rst),
        .fill_start  (fill_start),
        .fill_color  (fill_color),
        .swap_pulse  (swap_pulse),
        .fill_we     (fill_we),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .fill_active (fill_active)
    );

    scan_timing i_scan_timing (
        .clock       (clock),
        .rst         (rst),
        .scan_addr   (scan_addr),
        .scan_pixel  (scan_pixel),
        .pixel_out   (pixel_out),
        .pixel_valid (pixel_valid),
        .hsync       (hsync),
        .vsync       (vsync)
    );

    fb_double_buffer i_fb_double_buffer (
        .clock      (clock),
        .rst        (rst),
        .vsync      (vsync),
        .rd1_addr   (scan_addr),
        .rd1_data   (scan_pixel),
        .rd2_addr   (pix_raddr),
        .rd2_data   (pix_rdata),
        .wr1_en     (pix_we),
        .wr1_addr   (pix_waddr),
        .wr1_data   (pix_wdata),
        .wr2_en     (fill_we),
        .wr2_addr   (fill_addr),
        .wr2_data   (fill_data),
        .front_sel  (front_sel),
        .swap_pulse (swap_pulse)
    );

endmodule

//--- test/fb_checker.sv
`timescale 1ns/10ps

module fb_checker
    import fb_pkg::*;
(
    input logic      clock,
    input logic      rst,
    input axil_req_t req,
    input axil_rsp_t rsp,
    input logic      fill_start,
    input logic      fill_active
);

    logic ar_done_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            ar_done_q <= 1'b0;
        end else begin
            ar_done_q <= req.arvalid && rsp.arready;
        end
    end

    // response the cycle after an accepted write
    a_bvalid_follows: assert property (@(posedge clock) disable iff (rst)
        rsp.awready |=> rsp.bvalid)
        else $error("no write response after an accepted write");

    a_bvalid_hold: assert property (@(posedge clock) disable iff (rst)
        (rsp.bvalid && !req.bready) |=> rsp.bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clock) disable iff (rst)
        (rsp.rvalid && !req.rready) |=> (rsp.rvalid && $stable(rsp.rdata)))
        else $error("read data not held while stalled");

    // data two cycles after the address handshake
    a_read_latency: assert property (@(posedge clock) disable iff (rst)
        ar_done_q |=> rsp.rvalid)
        else $error("rvalid late after read address");

    // fill engine locks out host writes right after the command
    a_fill_lockout: assert property (@(posedge clock) disable iff (rst)
        fill_start |=> fill_active)
        else $error("fill command not taken by the fill engine");

endmodule

//--- test/fb_tb.sv
`timescale 1ns/10ps

module fb_tb
    import fb_pkg::*;
();

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // eight frames cover the whole run plus some slack
    localparam int TIMEOUT_CYCLES = 8 * FRAME_CYCLES + 1000;
    localparam int RANDOM_OPS = 300;

    logic      clock = 1'b0;
    logic      rst;
    axil_req_t req;
    axil_rsp_t rsp;
    pixel_t    pixel_out;
    logic      pixel_valid;
    logic      hsync;
    logic      vsync;

    // model of both banks and the bus state
    pixel_t      model_mem [2][FB_PIXELS];
    logic        model_known [2];
    logic        model_front;
    fb_count_t   model_frames;
    logic        fill_armed;
    pixel_t      fill_color;
    int          busy_left;
    logic        bpend;
    logic        rd_busy;
    int          rd_stage;
    logic [15:0] rd_addr;
    logic [31:0] rd_exp;
    logic        rd_exp_valid;
    logic        vsync_prev;
    int          h_pos;
    int          pix_idx;
    int          swaps;
    int          cycles;
    int          checks;
    int          errors;
    int          pix_checked;
    integer      seed;

    fb_top i_fb_top (
        .clock       (clock),
        .rst         (rst),
        .axil_req    (req),
        .axil_rsp    (rsp),
        .pixel_out   (pixel_out),
        .pixel_valid (pixel_valid),
        .hsync       (hsync),
        .vsync       (vsync)
    );

    bind axil_fb_slave fb_checker i_fb_checker (
        .clock       (clock),
        .rst         (rst),
        .req         (req),
        .rsp         (rsp),
        .fill_start  (fill_start),
        .fill_active (fill_active)
    );

    always #2 clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    function automatic logic is_pixel_addr(input logic [15:0] addr);
        return (addr[1:0] == 2'b00) && (addr[15:2] < 14'(FB_PIXELS));
    endfunction

    function automatic logic [31:0] status_word(input logic active);
        return {16'h0000, model_frames, 6'b000000, active, model_front};
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic write_word(input logic [15:0] addr, input logic [31:0] data);
        int hold;
        next_cycle();
        req.awvalid = 1'b1;
        req.awaddr = addr;
        req.wvalid = 1'b1;
        req.wdata = data;
        req.wstrb = 4'hf;
        do begin
            @(negedge clock);
        end while (!rsp.awready);
        next_cycle();
        req.awvalid = 1'b0;
        req.wvalid = 1'b0;
        // let the response wait a little
        hold = $random(seed) & 3;
        repeat (hold) next_cycle();
        req.bready = 1'b1;
        do begin
            @(negedge clock);
        end while (!rsp.bvalid);
        next_cycle();
        req.bready = 1'b0;
    endtask

    task automatic read_word(input logic [15:0] addr);
        int hold;
        next_cycle();
        req.arvalid = 1'b1;
        req.araddr = addr;
        do begin
            @(negedge clock);
        end while (!rsp.arready);
        next_cycle();
        req.arvalid = 1'b0;
        hold = $random(seed) & 3;
        repeat (hold) next_cycle();
        req.rready = 1'b1;
        do begin
            @(negedge clock);
        end while (!rsp.rvalid);
        next_cycle();
        req.rready = 1'b0;
    endtask

    task automatic wait_swaps(input int count);
        int target;
        target = swaps + count;
        while (swaps < target) @(posedge clock);
    endtask

    // run limit from the length of the test
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            if (!rst) begin
                cycles++;
            end
        end
        $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // model and checks sampled mid cycle where everything is settled
    always @(negedge clock) begin
        logic active_now;
        logic accept;
        if (!rst) begin
            active_now = fill_armed || (busy_left > 0);
            if (busy_left > 0) begin
                busy_left--;
            end
            accept = req.awvalid && req.wvalid && !bpend && !active_now;
            check_value("awready", 32'(accept), 32'(rsp.awready));
            check_value("wready", 32'(accept), 32'(rsp.wready));
            check_value("bvalid", 32'(bpend), 32'(rsp.bvalid));
            check_value("arready", 32'(!rd_busy), 32'(rsp.arready));
            // read data follows the front bank one cycle after acceptance
            if (rd_stage == 1) begin
                rd_exp = '0;
                rd_exp_valid = 1'b1;
                if (is_pixel_addr(rd_addr)) begin
                    rd_exp[3:0] = model_mem[model_front][rd_addr[11:2]];
                    rd_exp_valid = model_known[model_front];
                end
                rd_stage = 2;
            end else if (rd_stage == 2) begin
                if (rd_addr == STATUS_ADDR) begin
                    rd_exp = status_word(active_now);
                end
                check_value("rvalid", 32'(1), 32'(rsp.rvalid));
                rd_stage = 3;
            end
            if (rsp.rvalid && req.rready) begin
                if (rd_exp_valid) begin
                    check_value("rdata", rd_exp, rsp.rdata);
                end
                check_value("rresp", 32'(RESP_OKAY), 32'(rsp.rresp));
                rd_stage = 0;
                rd_busy = 1'b0;
            end
            if (req.arvalid && rsp.arready) begin
                rd_busy = 1'b1;
                rd_stage = 1;
                rd_addr = req.araddr;
            end
            if (rsp.bvalid && req.bready) begin
                check_value("bresp", 32'(RESP_OKAY), 32'(rsp.bresp));
                bpend = 1'b0;
            end
            if (accept) begin
                bpend = 1'b1;
                if (req.awaddr == CTRL_ADDR) begin
                    fill_armed = 1'b1;
                    fill_color = req.wdata[3:0];
                end else if (is_pixel_addr(req.awaddr)) begin
                    model_mem[!model_front][req.awaddr[11:2]] = req.wdata[3:0];
                end
            end
            // display stream in raster order
            if (pixel_valid) begin
                if (pix_idx < FB_PIXELS && model_known[model_front]) begin
                    check_value("pixel_out", 32'(model_mem[model_front][10'(pix_idx)]),
                                32'(pixel_out));
                    pix_checked++;
                end
                pix_idx++;
            end
            // vsync fall swaps the banks and an armed fill clears the new back bank
            if (vsync_prev && !vsync) begin
                check_value("pixel count", 32'(FB_PIXELS), 32'(pix_idx));
                pix_idx = 0;
                h_pos = 0;
                model_front = !model_front;
                model_frames++;
                swaps++;
                if (fill_armed) begin
                    for (int i = 0; i < FB_PIXELS; i++) begin
                        model_mem[!model_front][fb_addr_t'(i)] = fill_color;
                    end
                    model_known[!model_front] = 1'b1;
                    fill_armed = 1'b0;
                    busy_left = FB_PIXELS + 1;
                end
            end
            // raster column is known once the first vsync fall is seen
            if (h_pos >= 0) begin
                check_value("hsync", 32'(h_pos >= H_SYNC_FIRST && h_pos <= H_SYNC_LAST),
                            32'(hsync));
                h_pos = (h_pos + 1) % H_TOTAL;
            end
            vsync_prev = vsync;
        end
    end

    initial begin
        pixel_t color_a;
        int     op;
        int     idx;
        seed = 35375;
        rst = 1'b1;
        req = '0;
        model_known[0] = 1'b0;
        model_known[1] = 1'b0;
        model_front = 1'b0;
        model_frames = '0;
        fill_armed = 1'b0;
        fill_color = '0;
        busy_left = 0;
        bpend = 1'b0;
        rd_busy = 1'b0;
        rd_stage = 0;
        rd_addr = '0;
        rd_exp = '0;
        rd_exp_valid = 1'b0;
        vsync_prev = 1'b0;
        h_pos = -1;
        pix_idx = 0;
        swaps = 0;
        checks = 0;
        errors = 0;
        pix_checked = 0;
        repeat (10) @(posedge clock);
        #1;
        rst = 1'b0;
        // two fills in a row give both banks a known color
        color_a = pixel_t'($random(seed));
        write_word(CTRL_ADDR, 32'(color_a));
        // second fill and the pixel write below are held off by the running fill
        write_word(CTRL_ADDR, 32'(~color_a));
        read_word(STATUS_ADDR);
        idx = {$random(seed)} % FB_PIXELS;
        write_word(PIX_BASE + 16'(idx * 4), $random(seed));
        wait_swaps(1);
        for (int n = 0; n < RANDOM_OPS; n++) begin
            op = {$random(seed)} % 8;
            idx = {$random(seed)} % FB_PIXELS;
            case (op)
                0, 1, 2, 3: write_word(PIX_BASE + 16'(idx * 4), $random(seed));
                4, 5: read_word(PIX_BASE + 16'(idx * 4));
                6: read_word(STATUS_ADDR);
                default: read_word(16'h2000);
            endcase
        end
        // the last writes reach the display after the next swap
        wait_swaps(2);
        if (pix_checked == 0) begin
            errors++;
            $display("no display pixels were compared");
        end
        $display("checks: %0d, errors: %0d, display pixels compared: %0d",
                 checks, errors, pix_checked);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- fb_top.f
hdl/fb_pkg.sv
hdl/fb_bank.sv
hdl/fb_double_buffer.sv
hdl/scan_timing.sv
hdl/fill_engine.sv
hdl/axil_fb_slave.sv
hdl/fb_top.sv
test/fb_checker.sv
test/fb_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the framebuffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module fb_tb -f fb_top.f -o fb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\* FAIL \*\*" "$log"; then
    echo "simulation reported failure"
    exit 1
fi
exit 0
